//--- files.f
hdl/spy_pkg.sv
hdl/spi_cmd_decoder.sv
hdl/spi_write_buffer.sv
hdl/spy_regs.sv
hdl/spi_spy_top.sv
test/spi_spy_sva.sv
test/tb_spi_spy.sv

//--- Makefile
TOP := tb_spi_spy

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module spi_spy_top

obj_dir/V$(TOP): files.f $(wildcard hdl/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert -f files.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx 'TEST PASSED'

clean:
	rm -rf obj_dir

//--- test/tb_spi_spy.sv
// ########################################
// spi flash spy testbench
// flash bus model, host bus model and a
// table of transactions with expected records
// ########################################

`timescale 1ns/1ps

module tb_spi_spy;
	import spy_pkg::*;

	// one row of the stimulus table
	typedef struct packed {
		logic [7:0]  op;
		logic [23:0] addr;
		logic [7:0]  nbytes;  // total bytes on the bus
		logic [11:0] exp_len;
	} row_t;

	localparam int num_rows    = 9;
	localparam int half_clks   = 4;    // sclk half period in clocks
	localparam int row_budget  = 2500; // clocks per row, worst case is far below
	localparam int watchdog_ns = (num_rows * row_budget + 1000) * 8;

	localparam row_t table_rows [num_rows] = '{
		'{op_read,         24'h123456, 8'd7,  12'd3},
		'{op_fast_read,    24'hABCDEF, 8'd9,  12'd5},
		'{op_write_enable, 24'h000000, 8'd1,  12'd0},
		'{op_page_prog,    24'h0100FA, 8'd14, 12'd10}, // crosses 0xff
		'{op_read_status,  24'h000000, 8'd4,  12'd3},
		'{op_sector_erase, 24'h010000, 8'd4,  12'd0},
		'{8'h9F,           24'h000000, 8'd3,  12'd2},  // id read, no address
		'{op_page_prog,    24'h200022, 8'd10, 12'd6},
		'{op_read_status,  24'h000000, 8'd2,  12'd1}
	};

	logic        clk = 1'b0;
	logic        resetn;
	logic        spi_cs_n;
	logic        spi_sclk;
	logic        spi_mosi;
	logic        spi_miso;
	logic        spi_miso_oe;
	logic        iomem_valid;
	iomem_req_t  iomem_req;
	logic        iomem_ready;
	logic [31:0] iomem_rdata;

	logic [7:0]  tx_bytes [64];
	logic [7:0]  rx_bytes [64];
	logic        oe_seen; // miso driver seen on during the frame
	row_t        row;
	logic        addressed;
	int          hdr;
	logic [7:0]  status;
	logic [31:0] rdata;
	logic [23:0] ts;
	logic [23:0] prev_ts;
	logic [23:0] exp_addr;
	logic [7:0]  baddr;
	int          sent;
	int          errors;
	int          checks;
	int          sva_fails;

	spi_spy_top i_spi_spy_top (
		.clk         (clk),
		.resetn      (resetn),
		.spi_cs_n    (spi_cs_n),
		.spi_sclk    (spi_sclk),
		.spi_mosi    (spi_mosi),
		.spi_miso    (spi_miso),
		.spi_miso_oe (spi_miso_oe),
		.iomem_valid (iomem_valid),
		.iomem_req   (iomem_req),
		.iomem_ready (iomem_ready),
		.iomem_rdata (iomem_rdata)
	);

	bind spy_regs spi_spy_sva i_spi_spy_sva (
		.clk         (clk),
		.resetn      (resetn),
		.iomem_valid (iomem_valid),
		.iomem_ready (iomem_ready),
		.cmd_valid   (cmd_valid),
		.sr_valid    (sr_valid)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] spy_addr(input logic [7:0] off);
		return {spy_region, 12'h000, off};
	endfunction

	function automatic logic [31:0] wbuf_addr(input logic [7:0] byte_addr);
		return {wbuf_region, 12'h000, byte_addr[7:2], 2'b00};
	endfunction

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error at %0t ns: %s, got %h, expected %h", $time, what, actual,
				expected);
		end
	endtask

	// wait n rising edges, then step past them to drive
	task automatic tick(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic host_access(input logic [31:0] a, input logic [31:0] d,
			input logic [3:0] strb, output logic [31:0] rd);
		int waited;
		waited = 0;
		iomem_req.addr  = a;
		iomem_req.wdata = d;
		iomem_req.wstrb = strb;
		iomem_valid     = 1'b1;
		tick(1);
		while (iomem_ready !== 1'b1 && waited < 16) begin
			tick(1);
			waited++;
		end
		if (iomem_ready !== 1'b1) begin
			errors++;
			$display("host request to %h was never answered with ready", a);
		end
		rd          = iomem_rdata;
		iomem_valid = 1'b0;
		tick(1); // valid low for a cycle
	endtask

	task automatic host_read(input logic [31:0] a, output logic [31:0] rd);
		host_access(a, 32'h0, 4'b0000, rd);
	endtask

	task automatic host_write(input logic [31:0] a, input logic [31:0] d,
			input logic [3:0] strb);
		logic [31:0] unused_rd;
		host_access(a, d, strb, unused_rd);
	endtask

	// mode 0, msb first, miso taken on rising sclk
	task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
		for (int i = 7; i >= 0; i--) begin
			spi_mosi = tx[i];
			tick(half_clks);
			spi_sclk = 1'b1;
			rx[i]    = spi_miso;
			if (spi_miso_oe === 1'b1)
				oe_seen = 1'b1;
			tick(half_clks);
			spi_sclk = 1'b0;
		end
	endtask

	task automatic spi_frame(input int n);
		oe_seen  = 1'b0;
		spi_cs_n = 1'b0;
		for (int i = 0; i < n; i++)
			spi_byte(tx_bytes[i], rx_bytes[i]);
		tick(half_clks);
		spi_cs_n = 1'b1;
	endtask

	task automatic wait_record();
		int waited;
		waited = 0;
		while (i_spi_spy_top.cmd_valid !== 1'b1 && waited < 8) begin
			tick(1);
			waited++;
		end
		if (i_spi_spy_top.cmd_valid !== 1'b1) begin
			errors++;
			$display("no command record within 8 clocks of chip select rising, %0t ns",
				$time);
		end
		tick(1); // record visible from the next cycle
	endtask

	initial begin
		#(watchdog_ns);
		$display("watchdog expired after %0d ns, the run did not finish", watchdog_ns);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'hc951));
		resetn      = 1'b0;
		spi_cs_n    = 1'b1;
		spi_sclk    = 1'b0;
		spi_mosi    = 1'b0;
		iomem_valid = 1'b0;
		iomem_req   = '0;
		oe_seen     = 1'b0;
		status      = 8'h00;
		prev_ts     = '0;
		sent        = 0;
		errors      = 0;
		checks      = 0;
		tick(5);
		resetn = 1'b1;
		tick(2);

		for (int r = 0; r < num_rows; r++) begin
			row       = table_rows[r];
			addressed = row.op inside {op_read, op_fast_read, op_page_prog, op_sector_erase};
			if (row.op == op_read_status) begin
				status = 8'($urandom);
				host_write(spy_addr(reg_len_sr), {24'h0, status}, 4'b0001);
			end

			tx_bytes[0] = row.op;
			hdr         = 1;
			if (addressed) begin
				tx_bytes[1] = row.addr[23:16];
				tx_bytes[2] = row.addr[15:8];
				tx_bytes[3] = row.addr[7:0];
				hdr         = 4;
			end
			for (int i = hdr; i < int'(row.nbytes); i++)
				tx_bytes[i] = 8'($urandom);
			spi_frame(int'(row.nbytes));
			sent++;
			wait_record();

			exp_addr = addressed ? row.addr : 24'h0;
			host_read(spy_addr(reg_cmd), rdata);
			check(32'(rdata[7:0]), 32'(row.op), "opcode");
			ts = rdata[31:8];
			if (r > 0)
				check(32'(ts > prev_ts), 32'd1, "timestamp increases");
			prev_ts = ts;
			host_read(spy_addr(reg_addr), rdata);
			check(rdata, 32'(exp_addr), "address");
			host_read(spy_addr(reg_len_sr), rdata);
			check(32'(rdata[19:8]), 32'(row.exp_len), "len field");
			check(32'(rdata[7:0]), 32'(status), "status shadow");

			// only read-status drives miso
			check(32'(oe_seen), 32'(row.op == op_read_status), "miso driver during frame");
			if (row.op == op_read_status) begin
				for (int i = 1; i < int'(row.nbytes); i++)
					check(32'(rx_bytes[i]), 32'(status), "status byte on miso");
			end
			if (row.op == op_page_prog) begin
				for (int i = 4; i < int'(row.nbytes); i++) begin
					baddr = row.addr[7:0] + 8'(i - 4); // wraps at 256
					host_read(wbuf_addr(baddr), rdata);
					check(32'(rdata[{baddr[1:0], 3'b000} +: 8]), 32'(tx_bytes[i]),
						"write buffer byte");
				end
			end
		end

		host_read(spy_addr(reg_count), rdata);
		check(rdata, 32'(sent), "event count");
		host_read(32'h0500_0000, rdata);
		check(rdata, 32'h0, "unmapped region");
		host_read(spy_addr(8'h10), rdata);
		check(rdata, 32'h0, "unknown register offset");
		check(32'(spi_miso_oe), 32'd0, "miso driver off when idle");

		sva_fails = i_spi_spy_top.i_spy_regs.i_spi_spy_sva.fail_count;
		errors += sva_fails;
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors, sva_fails);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- test/spi_spy_sva.sv
// ########################################
// spy register block assertions
// host handshake and single-cycle strobes
// ########################################

`timescale 1ns/1ps

module spi_spy_sva (
	input logic clk,
	input logic resetn,
	input logic iomem_valid,
	input logic iomem_ready,
	input logic cmd_valid,
	input logic sr_valid
);

	int fail_count = 0; // read back by the testbench

	ready_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
		iomem_ready |=> !iomem_ready)
		else begin
			fail_count++;
			$error("iomem_ready high two cycles in a row");
		end

	// ready only answers a request seen the cycle before
	ready_after_valid: assert property (@(posedge clk) disable iff (!resetn)
		iomem_ready |-> $past(iomem_valid))
		else begin
			fail_count++;
			$error("iomem_ready without iomem_valid the cycle before");
		end

	cmd_valid_pulse: assert property (@(posedge clk) disable iff (!resetn)
		cmd_valid |=> !cmd_valid)
		else begin
			fail_count++;
			$error("cmd_valid longer than one cycle");
		end

	sr_valid_pulse: assert property (@(posedge clk) disable iff (!resetn)
		sr_valid |=> !sr_valid)
		else begin
			fail_count++;
			$error("sr_valid longer than one cycle");
		end

endmodule

//--- hdl/spi_spy_top.sv
// ########################################
// spi flash spy top level
// decoder, write buffer and host registers
// ########################################

`timescale 1ns/1ps

module spi_spy_top
	import spy_pkg::*;
(
	input  logic        clk,
	input  logic        resetn,
	input  logic        spi_cs_n,
	input  logic        spi_sclk,
	input  logic        spi_mosi,
	output logic        spi_miso,
	output logic        spi_miso_oe,
	input  logic        iomem_valid,
	input  iomem_req_t  iomem_req,
	output logic        iomem_ready,
	output logic [31:0] iomem_rdata
);

	logic        cmd_valid;
	spi_cmd_t    cmd;
	logic        wr_valid;
	wbuf_wr_t    wr;
	logic        sr_valid;
	logic [7:0]  sr_value;
	logic [5:0]  rd_index;
	logic [31:0] rd_word;

	spi_cmd_decoder i_spi_cmd_decoder (
		.clk         (clk),
		.resetn      (resetn),
		.spi_cs_n    (spi_cs_n),
		.spi_sclk    (spi_sclk),
		.spi_mosi    (spi_mosi),
		.spi_miso    (spi_miso),
		.spi_miso_oe (spi_miso_oe),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.wr_valid    (wr_valid),
		.wr          (wr),
		.sr_valid    (sr_valid),
		.sr_value    (sr_value)
	);

	spi_write_buffer i_spi_write_buffer (
		.clk      (clk),
		.wr_valid (wr_valid),
		.wr       (wr),
		.rd_index (rd_index),
		.rd_word  (rd_word)
	);

	spy_regs i_spy_regs (
		.clk         (clk),
		.resetn      (resetn),
		.iomem_valid (iomem_valid),
		.iomem_req   (iomem_req),
		.iomem_ready (iomem_ready),
		.iomem_rdata (iomem_rdata),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.sr_valid    (sr_valid),
		.sr_value    (sr_value),
		.rd_index    (rd_index),
		.rd_word     (rd_word)
	);

endmodule

//--- hdl/spy_regs.sv
// ########################################
// spy host register block
// timestamped last command, event count,
// status byte write and buffer read window
// ########################################

`timescale 1ns/1ps

module spy_regs
	import spy_pkg::*;
(
	input  logic        clk,
	input  logic        resetn,
	input  logic        iomem_valid,
	input  iomem_req_t  iomem_req,
	output logic        iomem_ready,
	output logic [31:0] iomem_rdata,
	input  logic        cmd_valid,
	input  spi_cmd_t    cmd,
	output logic        sr_valid,
	output logic [7:0]  sr_value,
	output logic [5:0]  rd_index,
	input  logic [31:0] rd_word
);

	logic [ts_width-1:0] timestamp;
	logic [ts_width-1:0] cmd_ts;
	spi_cmd_t            last_cmd;
	logic [15:0]         event_count;
	logic [7:0]          sr_shadow;

	logic        spy_sel;
	logic        wbuf_sel;
	logic [7:0]  offset;
	logic        take;    // first cycle of a request
	logic [31:0] reg_rdata;
	logic [31:0] rdata_q;
	logic        wbuf_rd; // current answer comes from the buffer

	assign spy_sel  = iomem_req.addr[31:20] == spy_region;
	assign wbuf_sel = iomem_req.addr[31:20] == wbuf_region;
	assign offset   = iomem_req.addr[7:0];
	assign rd_index = iomem_req.addr[7:2];
	assign take     = iomem_valid && !iomem_ready;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			timestamp   <= '0;
			event_count <= '0;
		end else begin
			timestamp <= timestamp + 1'b1; // free running
			if (cmd_valid)
				event_count <= event_count + 16'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			last_cmd <= cmd;
			cmd_ts   <= timestamp;
		end
	end

	always_comb begin
		reg_rdata = '0; // unknown offsets read zero
		case (offset)
			reg_cmd:    reg_rdata = {cmd_ts, last_cmd.cmd};
			reg_addr:   reg_rdata = {8'h00, last_cmd.addr};
			reg_len_sr: reg_rdata = {12'h000, last_cmd.len, sr_shadow};
			reg_count:  reg_rdata = {16'h0000, event_count};
			default:    reg_rdata = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			iomem_ready <= 1'b0;
			sr_valid    <= 1'b0;
			sr_shadow   <= '0;
			wbuf_rd     <= 1'b0;
		end else begin
			iomem_ready <= 1'b0;
			sr_valid    <= 1'b0;
			if (take) begin
				iomem_ready <= 1'b1;
				wbuf_rd     <= wbuf_sel;
				if (spy_sel && offset == reg_len_sr && iomem_req.wstrb[0]) begin
					sr_shadow <= iomem_req.wdata[7:0];
					sr_valid  <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			rdata_q <= spy_sel ? reg_rdata : 32'h0;
	end

	// buffer word arrives together with ready
	assign iomem_rdata = wbuf_rd ? rd_word : rdata_q;
	assign sr_value    = sr_shadow;

endmodule

//--- hdl/spi_write_buffer.sv
// ########################################
// page-program write buffer
// byte wide writes from the decoder, one
// registered 32-bit word read for the host
// ########################################

`timescale 1ns/1ps

module spi_write_buffer
	import spy_pkg::*;
(
	input  logic        clk,
	input  logic        wr_valid,
	input  wbuf_wr_t    wr,
	input  logic [5:0]  rd_index,
	output logic [31:0] rd_word
);

	logic [31:0] mem [wbuf_words];
	logic [5:0]  wr_index;
	logic [1:0]  wr_lane;

	assign wr_index = wr.addr[7:2];
	assign wr_lane  = wr.addr[1:0]; // byte lane in the word

	always_ff @(posedge clk) begin
		if (wr_valid)
			mem[wr_index][{wr_lane, 3'b000} +: 8] <= wr.data;
	end

	// read data one clock after the index
	always_ff @(posedge clk) begin
		rd_word <= mem[rd_index];
	end

endmodule

//--- hdl/spi_cmd_decoder.sv
// ########################################
// spi flash command decoder
// oversamples cs, sclk and mosi, builds one
// record per transaction, emits write bytes
// and answers read-status on miso
// ########################################

`timescale 1ns/1ps

module spi_cmd_decoder
	import spy_pkg::*;
(
	input  logic       clk,
	input  logic       resetn,
	input  logic       spi_cs_n,
	input  logic       spi_sclk,
	input  logic       spi_mosi,
	output logic       spi_miso,
	output logic       spi_miso_oe,
	output logic       cmd_valid,
	output spi_cmd_t   cmd,
	output logic       wr_valid,
	output wbuf_wr_t   wr,
	input  logic       sr_valid,
	input  logic [7:0] sr_value
);

	// two flop synchronizers, bit 1 is the usable one
	logic [1:0] cs_sync;
	logic [1:0] sclk_sync;
	logic [1:0] mosi_sync;
	logic       cs_prev;
	logic       sclk_prev;

	logic       active;
	logic       cs_fall;
	logic       cs_rise;
	logic       sclk_rise;
	logic       sclk_fall;

	logic [2:0] bit_cnt;
	logic [2:0] byte_cnt; // saturates at 4, header done
	logic [6:0] shift_in;
	logic [7:0] rx_byte;
	spi_cmd_t   cur;      // record being built

	logic [7:0] status;   // emulated status register
	logic       sr_mode;
	logic [2:0] tx_cnt;
	logic [7:0] tx_shift;

	function automatic logic is_addressed(input logic [7:0] op);
		return op inside {op_read, op_fast_read, op_page_prog, op_sector_erase};
	endfunction

	always_ff @(posedge clk) begin
		if (!resetn) begin
			cs_sync   <= 2'b11; // bus idle
			cs_prev   <= 1'b1;
			sclk_sync <= 2'b00;
			sclk_prev <= 1'b0;
		end else begin
			cs_sync   <= {cs_sync[0], spi_cs_n};
			cs_prev   <= cs_sync[1];
			sclk_sync <= {sclk_sync[0], spi_sclk};
			sclk_prev <= sclk_sync[1];
		end
	end

	always_ff @(posedge clk) begin
		mosi_sync <= {mosi_sync[0], spi_mosi};
	end

	assign active    = !cs_sync[1];
	assign cs_fall   = !cs_sync[1] && cs_prev;
	assign cs_rise   = cs_sync[1] && !cs_prev;
	assign sclk_rise = sclk_sync[1] && !sclk_prev;
	assign sclk_fall = !sclk_sync[1] && sclk_prev;
	assign rx_byte   = {shift_in, mosi_sync[1]};

	always_ff @(posedge clk) begin
		if (!resetn) begin
			bit_cnt     <= '0;
			byte_cnt    <= '0;
			cur         <= '0;
			cmd_valid   <= 1'b0;
			wr_valid    <= 1'b0;
			sr_mode     <= 1'b0;
			spi_miso_oe <= 1'b0;
		end else begin
			cmd_valid <= 1'b0;
			wr_valid  <= 1'b0;
			if (cs_fall) begin
				// start of a new transaction
				bit_cnt  <= '0;
				byte_cnt <= '0;
				cur      <= '0;
				sr_mode  <= 1'b0;
			end else if (cs_rise) begin
				cmd_valid   <= (byte_cnt != 3'd0); // need at least the opcode
				sr_mode     <= 1'b0;
				spi_miso_oe <= 1'b0;
			end else if (sclk_rise && active) begin
				bit_cnt  <= bit_cnt + 3'd1;
				shift_in <= rx_byte[6:0];
				if (bit_cnt == 3'd7) begin
					if (byte_cnt != 3'd4)
						byte_cnt <= byte_cnt + 3'd1;
					if (byte_cnt == 3'd0) begin
						cur.cmd <= rx_byte;
						if (rx_byte == op_read_status) begin
							sr_mode     <= 1'b1;
							spi_miso_oe <= 1'b1;
						end
					end else if (is_addressed(cur.cmd) && byte_cnt != 3'd4) begin
						cur.addr <= {cur.addr[15:0], rx_byte}; // msb first
					end else begin
						if (cur.len != '1)
							cur.len <= cur.len + 12'd1;
						if (cur.cmd == op_page_prog) begin
							wr_valid <= 1'b1;
							wr.addr  <= cur.addr[7:0] + cur.len[7:0]; // wraps at 256
							wr.data  <= rx_byte;
						end
					end
				end
			end
		end
	end

	assign cmd = cur;

	// status answer, each byte starts on the falling edge after the last
	always_ff @(posedge clk) begin
		if (!resetn) begin
			status   <= '0;
			tx_cnt   <= '0;
			tx_shift <= '0;
		end else begin
			if (sr_valid)
				status <= sr_value;
			if (cs_fall) begin
				tx_cnt <= '0;
			end else if (sclk_fall && sr_mode) begin
				tx_cnt <= tx_cnt + 3'd1;
				if (tx_cnt == 3'd0)
					tx_shift <= status; // reload every byte
				else
					tx_shift <= {tx_shift[6:0], 1'b0};
			end
		end
	end

	assign spi_miso = tx_shift[7];

endmodule

//--- hdl/spy_pkg.sv
// ########################################
// spi flash spy shared definitions
// record structs, host bus request,
// flash opcodes and the register map
// ########################################

package spy_pkg;

	// one finished flash transaction
	typedef struct packed {
		logic [7:0]  cmd;
		logic [23:0] addr;
		logic [11:0] len; // bytes after the header, saturating
	} spi_cmd_t;

	// one page-program data byte
	typedef struct packed {
		logic [7:0] addr; // byte address in the buffer
		logic [7:0] data;
	} wbuf_wr_t;

	// host request, held with iomem_valid
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
	} iomem_req_t;

	// flash opcodes
	localparam logic [7:0] op_read         = 8'h03;
	localparam logic [7:0] op_fast_read    = 8'h0B;
	localparam logic [7:0] op_page_prog    = 8'h02;
	localparam logic [7:0] op_sector_erase = 8'h20;
	localparam logic [7:0] op_read_status  = 8'h05;
	localparam logic [7:0] op_write_enable = 8'h06;

	// host address regions, bits 31:20
	localparam logic [11:0] spy_region  = 12'h040;
	localparam logic [11:0] wbuf_region = 12'h041;

	// register offsets, bits 7:0
	localparam logic [7:0] reg_cmd    = 8'h00;
	localparam logic [7:0] reg_addr   = 8'h04;
	localparam logic [7:0] reg_len_sr = 8'h08;
	localparam logic [7:0] reg_count  = 8'h0C;

	localparam int wbuf_words = 64;
	localparam int ts_width   = 24;

endpackage
